//--- rtl/vc_stream_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vc stream package
// field widths and beat layouts of the 128-bit packet stream
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package vc_stream_pkg;

   parameter int DATA_W   = 128;
   parameter int BARDEC_W = 8;
   parameter int BE_W     = 16;

   // beat towards the transaction layer
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              sop;
      logic              eop;
      logic              empty;   // upper quadword unused
      logic              err;
   } tx_beat_t;

   // beat from the transaction layer, sideband rides along
   typedef struct packed {
      logic [DATA_W-1:0]   data;
      logic                sop;
      logic                eop;
      logic                empty;   // upper quadword unused
      logic [BARDEC_W-1:0] bardec;  // bar hit
      logic [BE_W-1:0]     be;      // byte enables
   } rx_beat_t;

endpackage

//--- rtl/tlp_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlp package
// header field positions and size limits of transaction layer packets
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package tlp_pkg;

   // header byte 0 sits in the low dword of the first beat
   parameter int CHAN_BIT = 22;   // virtual channel select

   parameter int MAX_PAYLOAD_BYTES = 512;
   parameter int BEAT_BYTES        = 16;
   parameter int HDR_BEATS         = 1;   // 3/4 dw header fits one beat

   // longest legal packet in stream beats
   parameter int MAX_TLP_BEATS = MAX_PAYLOAD_BYTES / BEAT_BYTES + HDR_BEATS;

endpackage

//--- rtl/vc_stream_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vc stream interface
// valid/ready packet stream carrying one beat of any layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

interface vc_stream_if #(
   parameter type beat_t = logic
);

   logic  valid;
   logic  ready;
   beat_t beat;

   // producer side
   modport src (
      output valid,
      output beat,
      input  ready
   );

   // consumer side
   modport snk (
      input  valid,
      input  beat,
      output ready
   );

endinterface

//--- rtl/tx_vc_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transmit vc arbiter
// packet-atomic round robin between two transmit ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tx_vc_arbiter (
   input  logic       pld_clk,
   input  logic       rst,
   input  logic [1:0] req,      // port valid
   input  logic [1:0] sop_in,
   input  logic [1:0] eop_in,
   input  logic       xfer,     // beat taken by output stage
   output logic [1:0] grant
);

   typedef enum logic [1:0] {
      IDLE,
      HOLD0,
      HOLD1
   } state_t;

   state_t     state_q;
   state_t     state_d;
   logic       last_q;     // port served last
   logic [1:0] elig;
   logic [1:0] pick;
   logic       sop_xfer;
   logic       eop_xfer;

   assign elig = req & sop_in;   // only packet starts may win

   always_comb begin
      if (elig == 2'b11) begin
         pick = last_q ? 2'b01 : 2'b10;   // favour the other port
      end else begin
         pick = elig;
      end
   end

   // combinational in idle, from state once a packet is open
   always_comb begin
      case (state_q)
         HOLD0:   grant = 2'b01;
         HOLD1:   grant = 2'b10;
         default: grant = pick;
      endcase
   end

   assign sop_xfer = xfer & |(grant & sop_in);
   assign eop_xfer = xfer & |(grant & eop_in);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (sop_xfer && !eop_xfer) begin   // single beat stays idle
               state_d = grant[1] ? HOLD1 : HOLD0;
            end
         end
         default: begin
            if (eop_xfer) begin
               state_d = IDLE;
            end
         end
      endcase
   end

   always_ff @(posedge pld_clk) begin
      if (rst) begin
         state_q <= IDLE;
         last_q  <= 1'b1;   // port 0 goes first
      end else begin
         state_q <= state_d;
         if (sop_xfer && state_q == IDLE) begin
            last_q <= grant[1];
         end
      end
   end

   a_grant_onehot : assert property (@(posedge pld_clk) disable iff (rst)
      $onehot0(grant));

   // no switch between the sop and eop transfers of a packet
   a_grant_held : assert property (@(posedge pld_clk) disable iff (rst)
      (sop_xfer || state_q != IDLE) && !eop_xfer |=> $stable(grant));

endmodule

//--- rtl/tlp_beat_counter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tlp beat counter
// counts beats of the outgoing packet, flags those past the limit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tlp_beat_counter #(
   parameter int MAX_BEATS = tlp_pkg::MAX_TLP_BEATS
) (
   input  logic pld_clk,
   input  logic rst,
   input  logic xfer,
   input  logic sop,
   input  logic eop,
   output logic overlong
);

   localparam int CNT_W = $clog2(MAX_BEATS + 3);

   logic [CNT_W-1:0] cnt_q;      // beats already sent in this packet
   logic [CNT_W-1:0] beat_idx;   // position of the beat on offer

   assign beat_idx = sop ? CNT_W'(1) : cnt_q + CNT_W'(1);
   assign overlong = beat_idx > CNT_W'(MAX_BEATS);

   always_ff @(posedge pld_clk) begin
      if (rst) begin
         cnt_q <= '0;
      end else if (xfer) begin
         if (eop) begin
            cnt_q <= '0;
         end else if (overlong) begin
            cnt_q <= CNT_W'(MAX_BEATS + 1);   // saturate
         end else begin
            cnt_q <= beat_idx;
         end
      end
   end

endmodule

//--- rtl/vc_reg_slice.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vc register slice
// one-deep registered stage for a valid/ready stream of any beat type
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module vc_reg_slice #(
   parameter type beat_t = logic
) (
   input  logic       pld_clk,
   input  logic       rst,
   vc_stream_if.snk   in_s,
   vc_stream_if.src   out_s
);

   logic  valid_q;
   logic  rdy_en_q;   // low while in reset
   beat_t beat_q;

   // refill in the same cycle the held beat leaves
   assign in_s.ready = rdy_en_q & (~valid_q | out_s.ready);

   assign out_s.valid = valid_q;
   assign out_s.beat  = beat_q;

   always_ff @(posedge pld_clk) begin
      if (rst) begin
         valid_q  <= 1'b0;
         rdy_en_q <= 1'b0;
      end else begin
         rdy_en_q <= 1'b1;
         if (in_s.ready) begin
            valid_q <= in_s.valid;
         end
      end
   end

   always_ff @(posedge pld_clk) begin
      if (in_s.valid && in_s.ready) begin
         beat_q <= in_s.beat;
      end
   end

   // downstream stall must not disturb the offered beat
   a_out_held : assert property (@(posedge pld_clk) disable iff (rst)
      out_s.valid && !out_s.ready |=> out_s.valid && $stable(out_s.beat));

endmodule

//--- rtl/tx_vc_mux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// transmit vc mux
// merges two transmit ports packet by packet into one output stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tx_vc_mux #(
   parameter int MAX_BEATS = tlp_pkg::MAX_TLP_BEATS
) (
   input  logic     pld_clk,
   input  logic     rst,
   vc_stream_if.snk in0,
   vc_stream_if.snk in1,
   vc_stream_if.src out_s
);

   vc_stream_if #(.beat_t(vc_stream_pkg::tx_beat_t)) slice_in ();

   logic [1:0]              grant;
   logic                    xfer;
   logic                    overlong;
   vc_stream_pkg::tx_beat_t sel_beat;

   always_comb begin
      sel_beat     = grant[1] ? in1.beat : in0.beat;
      sel_beat.err = sel_beat.err | overlong;   // mark beats past the limit
   end

   assign slice_in.valid = |(grant & {in1.valid, in0.valid});
   assign slice_in.beat  = sel_beat;
   assign in0.ready      = grant[0] & slice_in.ready;
   assign in1.ready      = grant[1] & slice_in.ready;
   assign xfer           = slice_in.valid & slice_in.ready;

   tx_vc_arbiter u_arb (
      .pld_clk (pld_clk),
      .rst     (rst),
      .req     ({in1.valid, in0.valid}),
      .sop_in  ({in1.beat.sop, in0.beat.sop}),
      .eop_in  ({in1.beat.eop, in0.beat.eop}),
      .xfer    (xfer),
      .grant   (grant)
   );

   tlp_beat_counter #(.MAX_BEATS(MAX_BEATS)) u_cnt (
      .pld_clk  (pld_clk),
      .rst      (rst),
      .xfer     (xfer),
      .sop      (slice_in.beat.sop),
      .eop      (slice_in.beat.eop),
      .overlong (overlong)
   );

   vc_reg_slice #(.beat_t(vc_stream_pkg::tx_beat_t)) u_slice (
      .pld_clk (pld_clk),
      .rst     (rst),
      .in_s    (slice_in),
      .out_s   (out_s)
   );

endmodule

//--- rtl/rx_vc_demux.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// receive vc demux
// routes each received packet to the stage of its virtual channel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module rx_vc_demux (
   input  logic     pld_clk,
   input  logic     rst,
   vc_stream_if.snk in_s,
   vc_stream_if.src out0,
   vc_stream_if.src out1
);

   vc_stream_if #(.beat_t(vc_stream_pkg::rx_beat_t)) s0_in ();
   vc_stream_if #(.beat_t(vc_stream_pkg::rx_beat_t)) s1_in ();

   logic chan_q;   // channel of the open packet
   logic chan;

   // header bit on the first beat, held value afterwards
   assign chan = in_s.beat.sop ? in_s.beat.data[tlp_pkg::CHAN_BIT] : chan_q;

   always_ff @(posedge pld_clk) begin
      if (rst) begin
         chan_q <= 1'b0;
      end else if (in_s.valid && in_s.ready && in_s.beat.sop) begin
         chan_q <= in_s.beat.data[tlp_pkg::CHAN_BIT];
      end
   end

   assign s0_in.valid = in_s.valid & ~chan;
   assign s1_in.valid = in_s.valid & chan;
   assign s0_in.beat  = in_s.beat;   // sideband stays with its beat
   assign s1_in.beat  = in_s.beat;
   assign in_s.ready  = chan ? s1_in.ready : s0_in.ready;

   vc_reg_slice #(.beat_t(vc_stream_pkg::rx_beat_t)) u_slice0 (
      .pld_clk (pld_clk),
      .rst     (rst),
      .in_s    (s0_in),
      .out_s   (out0)
   );

   vc_reg_slice #(.beat_t(vc_stream_pkg::rx_beat_t)) u_slice1 (
      .pld_clk (pld_clk),
      .rst     (rst),
      .in_s    (s1_in),
      .out_s   (out1)
   );

endmodule

//--- rtl/sonic_vc_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sonic vc top
// two-channel packet stream block between the tl port and two apps
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sonic_vc_top #(
   parameter int MAX_BEATS = tlp_pkg::MAX_TLP_BEATS
) (
   input  logic                               pld_clk,
   input  logic                               rst,
   // transmit port 0
   input  logic                               tx0_valid,
   output logic                               tx0_ready,
   input  logic [vc_stream_pkg::DATA_W-1:0]   tx0_data,
   input  logic                               tx0_sop,
   input  logic                               tx0_eop,
   input  logic                               tx0_empty,
   input  logic                               tx0_err,
   // transmit port 1
   input  logic                               tx1_valid,
   output logic                               tx1_ready,
   input  logic [vc_stream_pkg::DATA_W-1:0]   tx1_data,
   input  logic                               tx1_sop,
   input  logic                               tx1_eop,
   input  logic                               tx1_empty,
   input  logic                               tx1_err,
   // merged transmit stream to the tl
   output logic                               txo_valid,
   input  logic                               txo_ready,
   output logic [vc_stream_pkg::DATA_W-1:0]   txo_data,
   output logic                               txo_sop,
   output logic                               txo_eop,
   output logic                               txo_empty,
   output logic                               txo_err,
   // receive stream from the tl
   input  logic                               rxi_valid,
   output logic                               rxi_ready,
   input  logic [vc_stream_pkg::DATA_W-1:0]   rxi_data,
   input  logic                               rxi_sop,
   input  logic                               rxi_eop,
   input  logic                               rxi_empty,
   input  logic [vc_stream_pkg::BARDEC_W-1:0] rxi_bardec,
   input  logic [vc_stream_pkg::BE_W-1:0]     rxi_be,
   // receive channel 0
   output logic                               rx0_valid,
   input  logic                               rx0_ready,
   output logic [vc_stream_pkg::DATA_W-1:0]   rx0_data,
   output logic                               rx0_sop,
   output logic                               rx0_eop,
   output logic                               rx0_empty,
   output logic [vc_stream_pkg::BARDEC_W-1:0] rx0_bardec,
   output logic [vc_stream_pkg::BE_W-1:0]     rx0_be,
   // receive channel 1
   output logic                               rx1_valid,
   input  logic                               rx1_ready,
   output logic [vc_stream_pkg::DATA_W-1:0]   rx1_data,
   output logic                               rx1_sop,
   output logic                               rx1_eop,
   output logic                               rx1_empty,
   output logic [vc_stream_pkg::BARDEC_W-1:0] rx1_bardec,
   output logic [vc_stream_pkg::BE_W-1:0]     rx1_be
);

   vc_stream_if #(.beat_t(vc_stream_pkg::tx_beat_t)) tx0_if ();
   vc_stream_if #(.beat_t(vc_stream_pkg::tx_beat_t)) tx1_if ();
   vc_stream_if #(.beat_t(vc_stream_pkg::tx_beat_t)) txo_if ();
   vc_stream_if #(.beat_t(vc_stream_pkg::rx_beat_t)) rxi_if ();
   vc_stream_if #(.beat_t(vc_stream_pkg::rx_beat_t)) rx0_if ();
   vc_stream_if #(.beat_t(vc_stream_pkg::rx_beat_t)) rx1_if ();

   // transmit side
   assign tx0_if.valid = tx0_valid;
   assign tx0_if.beat  = '{data: tx0_data, sop: tx0_sop, eop: tx0_eop,
                           empty: tx0_empty, err: tx0_err};
   assign tx0_ready    = tx0_if.ready;

   assign tx1_if.valid = tx1_valid;
   assign tx1_if.beat  = '{data: tx1_data, sop: tx1_sop, eop: tx1_eop,
                           empty: tx1_empty, err: tx1_err};
   assign tx1_ready    = tx1_if.ready;

   assign txo_valid    = txo_if.valid;
   assign txo_if.ready = txo_ready;
   assign txo_data     = txo_if.beat.data;
   assign txo_sop      = txo_if.beat.sop;
   assign txo_eop      = txo_if.beat.eop;
   assign txo_empty    = txo_if.beat.empty;
   assign txo_err      = txo_if.beat.err;

   // receive side
   assign rxi_if.valid = rxi_valid;
   assign rxi_if.beat  = '{data: rxi_data, sop: rxi_sop, eop: rxi_eop,
                           empty: rxi_empty, bardec: rxi_bardec, be: rxi_be};
   assign rxi_ready    = rxi_if.ready;

   assign rx0_valid    = rx0_if.valid;
   assign rx0_if.ready = rx0_ready;
   assign rx0_data     = rx0_if.beat.data;
   assign rx0_sop      = rx0_if.beat.sop;
   assign rx0_eop      = rx0_if.beat.eop;
   assign rx0_empty    = rx0_if.beat.empty;
   assign rx0_bardec   = rx0_if.beat.bardec;
   assign rx0_be       = rx0_if.beat.be;

   assign rx1_valid    = rx1_if.valid;
   assign rx1_if.ready = rx1_ready;
   assign rx1_data     = rx1_if.beat.data;
   assign rx1_sop      = rx1_if.beat.sop;
   assign rx1_eop      = rx1_if.beat.eop;
   assign rx1_empty    = rx1_if.beat.empty;
   assign rx1_bardec   = rx1_if.beat.bardec;
   assign rx1_be       = rx1_if.beat.be;

   tx_vc_mux #(.MAX_BEATS(MAX_BEATS)) u_tx_mux (
      .pld_clk (pld_clk),
      .rst     (rst),
      .in0     (tx0_if),
      .in1     (tx1_if),
      .out_s   (txo_if)
   );

   rx_vc_demux u_rx_demux (
      .pld_clk (pld_clk),
      .rst     (rst),
      .in_s    (rxi_if),
      .out0    (rx0_if),
      .out1    (rx1_if)
   );

endmodule

//--- dv/vc_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// vc checker
// expected beat queues per port, compares txo, rx0 and rx1 transfers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module vc_checker (
   input logic                               pld_clk,
   input logic                               rst,
   input logic                               txo_valid,
   input logic                               txo_ready,
   input logic [vc_stream_pkg::DATA_W-1:0]   txo_data,
   input logic                               txo_sop,
   input logic                               txo_eop,
   input logic                               txo_empty,
   input logic                               txo_err,
   input logic                               rx0_valid,
   input logic                               rx0_ready,
   input logic [vc_stream_pkg::DATA_W-1:0]   rx0_data,
   input logic                               rx0_sop,
   input logic                               rx0_eop,
   input logic                               rx0_empty,
   input logic [vc_stream_pkg::BARDEC_W-1:0] rx0_bardec,
   input logic [vc_stream_pkg::BE_W-1:0]     rx0_be,
   input logic                               rx1_valid,
   input logic                               rx1_ready,
   input logic [vc_stream_pkg::DATA_W-1:0]   rx1_data,
   input logic                               rx1_sop,
   input logic                               rx1_eop,
   input logic                               rx1_empty,
   input logic [vc_stream_pkg::BARDEC_W-1:0] rx1_bardec,
   input logic [vc_stream_pkg::BE_W-1:0]     rx1_be
);

   logic [131:0] txq0[$];   // data, sop, eop, empty, err
   logic [131:0] txq1[$];
   logic [154:0] rxq0[$];   // data, sop, eop, empty, bardec, be
   logic [154:0] rxq1[$];
   int           src_log[$];   // source port of each txo packet
   int           err_cnt = 0;
   int           test_err = 0;
   int           rx1_eop_cnt = 0;
   logic         in_pkt = 1'b0;
   logic         cur_src = 1'b0;

   task automatic expect_tx(input logic port, input logic [131:0] beat);
      if (port) txq1.push_back(beat);
      else txq0.push_back(beat);
   endtask

   task automatic expect_rx(input logic chan, input logic [154:0] beat);
      if (chan) rxq1.push_back(beat);
      else rxq0.push_back(beat);
   endtask

   function automatic int pending();
      return txq0.size() + txq1.size() + rxq0.size() + rxq1.size();
   endfunction

   task automatic report_error(input string msg);
      $display("error at %0t: %s", $time, msg);
      err_cnt++;
      test_err++;
   endtask

   task automatic check_tx(input logic src, input logic [131:0] got);
      logic [131:0] exp;
      if ((src ? txq1.size() : txq0.size()) == 0) begin
         report_error($sformatf("unexpected txo beat %h", got));
      end else begin
         exp = src ? txq1.pop_front() : txq0.pop_front();
         if (exp != got) begin
            report_error($sformatf("txo from port %0d expected %h got %h", src, exp, got));
         end
      end
   endtask

   task automatic check_rx(input logic chan, input logic [154:0] got);
      logic [154:0] exp;
      if ((chan ? rxq1.size() : rxq0.size()) == 0) begin
         report_error($sformatf("unexpected beat on rx%0d: %h", chan, got));
      end else begin
         exp = chan ? rxq1.pop_front() : rxq0.pop_front();
         if (exp != got) begin
            report_error($sformatf("rx%0d expected %h got %h", chan, exp, got));
         end
      end
   endtask

   // packets of the two ports must take turns
   task automatic check_alternate();
      for (int i = 1; i < src_log.size(); i++) begin
         if (src_log[i] == src_log[i-1]) begin
            report_error($sformatf("txo packet %0d repeats port %0d", i, src_log[i]));
         end
      end
   endtask

   task automatic end_test(input string name, output int errs);
      if (pending() != 0) begin
         report_error($sformatf("%0d beats never came out", pending()));
      end
      if (test_err == 0) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, test_err);
      errs = test_err;
      test_err = 0;
      src_log.delete();
   endtask

   always @(posedge pld_clk) begin
      logic [131:0] got;
      logic         src;
      if (rst) begin
         in_pkt = 1'b0;
      end else if (txo_valid && txo_ready) begin
         got = {txo_data, txo_sop, txo_eop, txo_empty, txo_err};
         src = cur_src;
         if (!in_pkt) begin   // new packet, find its port by head match
            src = (txq1.size() != 0 && txq1[0] == got) ? 1'b1 : 1'b0;
            src_log.push_back(int'(src));
         end
         check_tx(src, got);
         cur_src = src;
         in_pkt = !txo_eop;
      end
   end

   always @(posedge pld_clk) begin
      if (!rst && rx0_valid && rx0_ready) begin
         check_rx(1'b0, {rx0_data, rx0_sop, rx0_eop, rx0_empty, rx0_bardec, rx0_be});
      end
      if (!rst && rx1_valid && rx1_ready) begin
         check_rx(1'b1, {rx1_data, rx1_sop, rx1_eop, rx1_empty, rx1_bardec, rx1_be});
         if (rx1_eop) rx1_eop_cnt++;
      end
   end

endmodule

//--- dv/tb_sonic_vc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sonic vc testbench
// clock, reset, packet table driven on both paths, timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_sonic_vc;

   localparam int MAX_BEATS = 33;
   localparam int N_PKTS    = 19;
   localparam int N_TESTS   = 6;

   // port 0/1 are tx inputs, port 2 is rxi
   typedef struct packed {
      logic [3:0] test;
      logic [1:0] port;
      logic [7:0] len;
      logic       chan;
      logic       err;
   } pkt_t;

   pkt_t pkts[N_PKTS] = '{
      '{4'd0, 2'd0, 8'd4,  1'b0, 1'b0},
      '{4'd1, 2'd0, 8'd3,  1'b0, 1'b0},
      '{4'd1, 2'd0, 8'd5,  1'b0, 1'b0},
      '{4'd1, 2'd1, 8'd2,  1'b0, 1'b0},
      '{4'd1, 2'd1, 8'd4,  1'b0, 1'b0},
      '{4'd2, 2'd0, 8'd34, 1'b0, 1'b0},
      '{4'd2, 2'd1, 8'd33, 1'b0, 1'b0},
      '{4'd2, 2'd0, 8'd2,  1'b0, 1'b1},
      '{4'd3, 2'd2, 8'd3,  1'b0, 1'b0},
      '{4'd3, 2'd2, 8'd2,  1'b1, 1'b0},
      '{4'd3, 2'd2, 8'd1,  1'b0, 1'b0},
      '{4'd3, 2'd2, 8'd4,  1'b1, 1'b0},
      '{4'd4, 2'd0, 8'd6,  1'b0, 1'b0},
      '{4'd4, 2'd1, 8'd5,  1'b0, 1'b1},
      '{4'd4, 2'd2, 8'd5,  1'b1, 1'b0},
      '{4'd4, 2'd2, 8'd4,  1'b0, 1'b0},
      '{4'd4, 2'd0, 8'd1,  1'b0, 1'b0},
      '{4'd5, 2'd2, 8'd1,  1'b0, 1'b0},
      '{4'd5, 2'd2, 8'd3,  1'b1, 1'b0}
   };

   string      test_name[N_TESTS] = '{"single_tx0", "merge_alternate", "overlong",
                                      "rx_route", "random_stall", "rx_no_block"};
   logic [1:0] test_mode[N_TESTS] = '{2'd0, 2'd0, 2'd0, 2'd0, 2'd1, 2'd2};  // ready pattern
   logic       test_alt[N_TESTS]  = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};

   logic         pld_clk;
   logic         rst;
   logic [1:0]   tx_valid;
   logic [1:0]   tx_ready;
   logic [127:0] tx_data[2];
   logic [1:0]   tx_sop;
   logic [1:0]   tx_eop;
   logic [1:0]   tx_empty;
   logic [1:0]   tx_err;
   logic         txo_valid, txo_ready, txo_sop, txo_eop, txo_empty, txo_err;
   logic [127:0] txo_data;
   logic         rxi_valid, rxi_ready, rxi_sop, rxi_eop, rxi_empty;
   logic [127:0] rxi_data;
   logic [7:0]   rxi_bardec;
   logic [15:0]  rxi_be;
   logic         rx0_valid, rx0_ready, rx0_sop, rx0_eop, rx0_empty;
   logic [127:0] rx0_data;
   logic [7:0]   rx0_bardec;
   logic [15:0]  rx0_be;
   logic         rx1_valid, rx1_ready, rx1_sop, rx1_eop, rx1_empty;
   logic [127:0] rx1_data;
   logic [7:0]   rx1_bardec;
   logic [15:0]  rx1_be;
   logic [1:0]   mode;
   int           rx1_base;
   int           cycles;
   int           limit;

   sonic_vc_top #(.MAX_BEATS(MAX_BEATS)) u_sonic_vc_top (
      .pld_clk (pld_clk), .rst (rst),
      .tx0_valid (tx_valid[0]), .tx0_ready (tx_ready[0]), .tx0_data (tx_data[0]),
      .tx0_sop (tx_sop[0]), .tx0_eop (tx_eop[0]), .tx0_empty (tx_empty[0]),
      .tx0_err (tx_err[0]),
      .tx1_valid (tx_valid[1]), .tx1_ready (tx_ready[1]), .tx1_data (tx_data[1]),
      .tx1_sop (tx_sop[1]), .tx1_eop (tx_eop[1]), .tx1_empty (tx_empty[1]),
      .tx1_err (tx_err[1]),
      .txo_valid (txo_valid), .txo_ready (txo_ready), .txo_data (txo_data),
      .txo_sop (txo_sop), .txo_eop (txo_eop), .txo_empty (txo_empty), .txo_err (txo_err),
      .rxi_valid (rxi_valid), .rxi_ready (rxi_ready), .rxi_data (rxi_data),
      .rxi_sop (rxi_sop), .rxi_eop (rxi_eop), .rxi_empty (rxi_empty),
      .rxi_bardec (rxi_bardec), .rxi_be (rxi_be),
      .rx0_valid (rx0_valid), .rx0_ready (rx0_ready), .rx0_data (rx0_data),
      .rx0_sop (rx0_sop), .rx0_eop (rx0_eop), .rx0_empty (rx0_empty),
      .rx0_bardec (rx0_bardec), .rx0_be (rx0_be),
      .rx1_valid (rx1_valid), .rx1_ready (rx1_ready), .rx1_data (rx1_data),
      .rx1_sop (rx1_sop), .rx1_eop (rx1_eop), .rx1_empty (rx1_empty),
      .rx1_bardec (rx1_bardec), .rx1_be (rx1_be)
   );

   vc_checker u_chk (.*);

   initial begin
      pld_clk = 1'b0;
      forever #20 pld_clk = ~pld_clk;
   end

   always @(posedge pld_clk) begin
      cycles = cycles + 1;
      if (cycles >= limit) begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // output back-pressure per test
   always @(posedge pld_clk) begin
      case (mode)
         2'd1: begin
            txo_ready <= 1'($urandom);
            rx0_ready <= 1'($urandom);
            rx1_ready <= 1'($urandom);
         end
         2'd2: begin   // rx0 held until a ch1 packet got through
            txo_ready <= 1'b1;
            rx0_ready <= u_chk.rx1_eop_cnt > rx1_base;
            rx1_ready <= 1'b1;
         end
         default: begin
            txo_ready <= 1'b1;
            rx0_ready <= 1'b1;
            rx1_ready <= 1'b1;
         end
      endcase
   end

   task automatic send_tx(input int idx);
      logic         p;
      logic         eop;
      logic         empty;
      logic         err;
      logic [127:0] d;
      p = pkts[idx].port[0];
      for (int b = 1; b <= int'(pkts[idx].len); b++) begin
         d = {$urandom, $urandom, $urandom, $urandom};
         eop = b == int'(pkts[idx].len);
         empty = eop & 1'($urandom);
         err = pkts[idx].err & eop;   // input err on the last beat
         tx_valid[p] <= 1'b1;
         tx_data[p]  <= d;
         tx_sop[p]   <= b == 1;
         tx_eop[p]   <= eop;
         tx_empty[p] <= empty;
         tx_err[p]   <= err;
         u_chk.expect_tx(p, {d, b == 1, eop, empty, err | (b > MAX_BEATS)});
         do @(posedge pld_clk); while (!tx_ready[p]);
      end
   endtask

   task automatic send_rx(input int idx);
      logic         eop;
      logic         empty;
      logic [7:0]   bd;
      logic [15:0]  be;
      logic [127:0] d;
      for (int b = 1; b <= int'(pkts[idx].len); b++) begin
         d = {$urandom, $urandom, $urandom, $urandom};
         if (b == 1) d[tlp_pkg::CHAN_BIT] = pkts[idx].chan;
         eop = b == int'(pkts[idx].len);
         empty = eop & 1'($urandom);
         bd = 8'($urandom);
         be = 16'($urandom);
         rxi_valid  <= 1'b1;
         rxi_data   <= d;
         rxi_sop    <= b == 1;
         rxi_eop    <= eop;
         rxi_empty  <= empty;
         rxi_bardec <= bd;
         rxi_be     <= be;
         u_chk.expect_rx(pkts[idx].chan, {d, b == 1, eop, empty, bd, be});
         do @(posedge pld_clk); while (!rxi_ready);
      end
   endtask

   // packets of one port back to back, in table order
   task automatic run_port(input int t, input int port);
      for (int i = 0; i < N_PKTS; i++) begin
         if (int'(pkts[i].test) == t && int'(pkts[i].port) == port) begin
            if (port == 2) send_rx(i);
            else send_tx(i);
         end
      end
      if (port == 2) rxi_valid <= 1'b0;
      else tx_valid[port] <= 1'b0;
   endtask

   initial begin
      int total;
      int failed;
      int errs;
      void'($urandom(32'hcfb4634e));
      rst = 1'b1;
      mode = 2'd0;
      rx1_base = 0;
      cycles = 0;
      tx_valid = 2'b00;
      tx_data[0] = '0;
      tx_data[1] = '0;
      tx_sop = 2'b00;
      tx_eop = 2'b00;
      tx_empty = 2'b00;
      tx_err = 2'b00;
      txo_ready = 1'b0;
      rxi_valid = 1'b0;
      rxi_data = '0;
      rxi_sop = 1'b0;
      rxi_eop = 1'b0;
      rxi_empty = 1'b0;
      rxi_bardec = '0;
      rxi_be = '0;
      rx0_ready = 1'b0;
      rx1_ready = 1'b0;
      total = 0;
      failed = 0;
      for (int i = 0; i < N_PKTS; i++) total += int'(pkts[i].len);
      limit = total * 4 + 100;
      repeat (3) @(posedge pld_clk);
      rst <= 1'b0;
      @(posedge pld_clk);
      if (txo_valid || rx0_valid || rx1_valid) begin
         u_chk.report_error("valid output high after reset");
      end
      for (int t = 0; t < N_TESTS; t++) begin
         mode <= test_mode[t];
         rx1_base = u_chk.rx1_eop_cnt;
         fork
            run_port(t, 0);
            run_port(t, 1);
            run_port(t, 2);
         join
         while (u_chk.pending() != 0) @(posedge pld_clk);
         if (test_alt[t]) u_chk.check_alternate();
         u_chk.end_test(test_name[t], errs);
         if (errs != 0) failed++;
      end
      $display("tests %0d, failed %0d, errors %0d", N_TESTS, failed, u_chk.err_cnt);
      if (failed == 0 && u_chk.err_cnt == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- src.f
rtl/vc_stream_pkg.sv
rtl/tlp_pkg.sv
rtl/vc_stream_if.sv
rtl/tx_vc_arbiter.sv
rtl/tlp_beat_counter.sv
rtl/vc_reg_slice.sv
rtl/tx_vc_mux.sv
rtl/rx_vc_demux.sv
rtl/sonic_vc_top.sv
dv/vc_checker.sv
dv/tb_sonic_vc.sv

//--- run.sh
#!/bin/sh
# build and run the sonic vc testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_sonic_vc -f src.f \
   --Mdir obj_dir -o sim_vc > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "build failed"
   exit 1
fi

./obj_dir/sim_vc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "TESTS FAILED" sim.log; then
   exit 1
fi

if ! grep -q "TESTS PASSED" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

exit 0
